// ==== rtl/cgra_pkg.sv ====
package cgra_pkg;

  localparam int DATA_W  = 16;
  localparam int INST_W  = 16;
  localparam int PC_W    = 8;
  localparam int RF_AW   = 3;
  localparam int PE_ID_W = 8;
  localparam int CONF_W  = 60;
  localparam int CNT_W   = 8;

  localparam int IMEM_DEPTH = 1 << PC_W;
  localparam int RF_DEPTH   = 1 << RF_AW;

  localparam int FIFO_DEPTH  = 4;
  localparam int FIFO_AW     = $clog2(FIFO_DEPTH);
  localparam int FIFO_CW     = $clog2(FIFO_DEPTH + 1);
  localparam int OUT_CREDITS = 4;
  localparam int OUT_CRED_W  = $clog2(OUT_CREDITS + 1);

  // Instruction fields, high to low: op, a_sel, b_sel, dst, rf_raddr, rf_waddr.
  localparam int INST_OP_LSB  = 12;
  localparam int INST_A_LSB   = 10;
  localparam int INST_B_LSB   = 8;
  localparam int INST_DST_LSB = 6;
  localparam int INST_RR_LSB  = 3;
  localparam int INST_RW_LSB  = 0;

  // Configuration word fields; bits 23:0 are spare.
  localparam int CONF_VALID_BIT = 59;
  localparam int CONF_ID_LSB    = 51;
  localparam int CONF_KIND_LSB  = 48;
  localparam int CONF_ADDR_LSB  = 40;
  localparam int CONF_DATA_LSB  = 24;

  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [INST_W-1:0]  inst_t;
  typedef logic [PC_W-1:0]    pc_t;
  typedef logic [RF_AW-1:0]   rf_addr_t;
  typedef logic [PE_ID_W-1:0] pe_id_t;
  typedef logic [CONF_W-1:0]  conf_word_t;
  typedef logic [CNT_W-1:0]   cnt_t;

  typedef enum logic [2:0] {
    CONF_INST    = 3'd0,
    CONF_CONST   = 3'd1,
    CONF_PC_MAX  = 3'd2,
    CONF_PC_LOOP = 3'd3,
    CONF_IGNORE  = 3'd4
  } conf_kind_t;

  typedef enum logic [1:0] {SRC_NA, SRC_NB, SRC_RF, SRC_STREAM} src_sel_t;

  typedef enum logic [1:0] {DST_NA, DST_NB, DST_RF, DST_STREAM} dst_sel_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SHL, ALU_SHR, ALU_PASS, ALU_MUL
  } alu_op_t;

endpackage

// ==== rtl/conf_if.sv ====
`timescale 1ns/10ps

interface conf_if;

  import cgra_pkg::*;

  logic     inst_we;
  pc_t      inst_addr;
  inst_t    inst_data;
  logic     const_we;
  rf_addr_t const_addr;
  data_t    const_data;
  pc_t      pc_max;
  pc_t      pc_loop;
  cnt_t     ignore_until;
  logic     run;          // Set once pc_max has been written.

  modport source (output inst_we, inst_addr, inst_data, const_we, const_addr, const_data,
                  pc_max, pc_loop, ignore_until, run);

  modport sink (input inst_we, inst_addr, inst_data, const_we, const_addr, const_data,
                pc_max, pc_loop, ignore_until, run);

endinterface

// ==== rtl/conf_reader.sv ====
`timescale 1ns/10ps

module conf_reader #(
  parameter cgra_pkg::pe_id_t PE_ID = 8'd0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  cgra_pkg::conf_word_t conf_bus,
  conf_if.source               conf
);

  import cgra_pkg::*;

  logic       bus_valid;
  pe_id_t     bus_id;
  conf_kind_t bus_kind;
  pc_t        bus_addr;
  data_t      bus_data;
  logic       hit;

  assign bus_valid = conf_bus[CONF_VALID_BIT];
  assign bus_id    = conf_bus[CONF_ID_LSB +: PE_ID_W];
  assign bus_kind  = conf_kind_t'(conf_bus[CONF_KIND_LSB +: $bits(conf_kind_t)]);
  assign bus_addr  = conf_bus[CONF_ADDR_LSB +: PC_W];
  assign bus_data  = conf_bus[CONF_DATA_LSB +: DATA_W];
  assign hit       = bus_valid && (bus_id == PE_ID);

  always_ff @(posedge clk) begin
    if (reset) begin
      conf.inst_we      <= 1'b0;
      conf.const_we     <= 1'b0;
      conf.pc_max       <= '0;
      conf.pc_loop      <= '0;
      conf.ignore_until <= '0;
      conf.run          <= 1'b0;
    end else begin
      conf.inst_we  <= hit && (bus_kind == CONF_INST);
      conf.const_we <= hit && (bus_kind == CONF_CONST);
      if (hit) begin
        case (bus_kind)
          CONF_PC_MAX: begin
            conf.pc_max <= bus_data[PC_W-1:0];
            conf.run    <= 1'b1;               // The PE starts on its first pc_max write.
          end
          CONF_PC_LOOP: conf.pc_loop      <= bus_data[PC_W-1:0];
          CONF_IGNORE:  conf.ignore_until <= bus_data[CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // Write payloads follow the strobes by the same single cycle.
  always_ff @(posedge clk) begin
    conf.inst_addr  <= bus_addr;
    conf.inst_data  <= bus_data;
    conf.const_addr <= bus_addr[RF_AW-1:0];
    conf.const_data <= bus_data;
  end

endmodule

// ==== rtl/stream_fifo.sv ====
`timescale 1ns/10ps

module stream_fifo (
  input  logic            clk,
  input  logic            reset,
  input  logic            push,
  input  cgra_pkg::data_t push_data,
  input  logic            pop,
  output cgra_pkg::data_t pop_data,
  output logic            empty,
  output logic            credit
);

  import cgra_pkg::*;

  data_t              mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_CW-1:0] count;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full     = (count == FIFO_CW'(FIFO_DEPTH));
  assign empty    = (count == '0);
  assign do_push  = push && !full;
  assign do_pop   = pop && !empty;
  assign pop_data = mem[rd_ptr];    // Read in the cycle of the pop.
  assign credit   = pop;            // One credit goes back per popped word.

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + FIFO_CW'(do_push) - FIFO_CW'(do_pop);
    end
  end

endmodule

// ==== rtl/pe_alu.sv ====
`timescale 1ns/10ps

module pe_alu (
  input  logic              clk,
  input  logic              en,
  input  cgra_pkg::alu_op_t op,
  input  cgra_pkg::data_t   a,
  input  cgra_pkg::data_t   b,
  output cgra_pkg::data_t   result
);

  import cgra_pkg::*;

  data_t res_next;

  // All results wrap to the 16-bit word.
  always_comb begin
    case (op)
      ALU_ADD:  res_next = a + b;
      ALU_SUB:  res_next = a - b;
      ALU_AND:  res_next = a & b;
      ALU_OR:   res_next = a | b;
      ALU_XOR:  res_next = a ^ b;
      ALU_SHL:  res_next = a << 1;
      ALU_SHR:  res_next = a >> 1;
      ALU_PASS: res_next = a;
      ALU_MUL:  res_next = a * b;   // Low half of the product.
      default:  res_next = a;
    endcase
  end

  always_ff @(posedge clk) begin
    if (en) begin
      result <= res_next;
    end
  end

endmodule

// ==== rtl/pe_io.sv ====
`timescale 1ns/10ps

module pe_io (
  input  logic            clk,
  input  logic            reset,
  conf_if.sink            conf,
  input  cgra_pkg::data_t ina,
  input  cgra_pkg::data_t inb,
  output cgra_pkg::data_t outa,
  output cgra_pkg::data_t outb,
  input  cgra_pkg::data_t fifo_data,
  input  logic            fifo_empty,
  output logic            fifo_pop,
  output logic            out_valid,
  output cgra_pkg::data_t out_data,
  input  logic            out_credit
);

  import cgra_pkg::*;

  inst_t imem [IMEM_DEPTH];
  data_t rf [RF_DEPTH];
  pc_t   pc_q;

  // Stage 1, fetch.
  logic  v1;
  inst_t inst1;

  // Stage 2, decode and register-file read.
  logic     v2;
  alu_op_t  op2;
  src_sel_t a_sel2;
  src_sel_t b_sel2;
  dst_sel_t dst2;
  rf_addr_t waddr2;
  data_t    rf2;
  data_t    ina2;
  data_t    inb2;

  // Stage 3, operand select.
  logic     v3;
  alu_op_t  op3;
  dst_sel_t dst3;
  rf_addr_t waddr3;
  data_t    a3;
  data_t    b3;

  // Stage 4, ALU.
  logic     v4;
  dst_sel_t dst4;
  rf_addr_t waddr4;
  data_t    result4;

  logic                  adv;
  logic                  need_in;
  logic                  to_stream;
  logic                  send;
  logic                  warm_done;
  cnt_t                  warm_cnt;
  logic [OUT_CRED_W-1:0] credits;

  function automatic data_t pick(src_sel_t sel, data_t na, data_t nb, data_t rfv, data_t st);
    case (sel)
      SRC_NA:  return na;
      SRC_NB:  return nb;
      SRC_RF:  return rfv;
      default: return st;
    endcase
  endfunction

  assign need_in   = v2 && ((a_sel2 == SRC_STREAM) || (b_sel2 == SRC_STREAM));
  assign to_stream = v4 && (dst4 == DST_STREAM);
  assign warm_done = (warm_cnt >= conf.ignore_until);
  assign send      = to_stream && warm_done;   // Suppressed results need no credit.

  // One enable moves every stage, so a stall holds the whole pipeline.
  assign adv      = !(need_in && fifo_empty) && !(send && (credits == '0));
  assign fifo_pop = need_in && adv;

  always_ff @(posedge clk) begin
    if (conf.inst_we) begin
      imem[conf.inst_addr] <= conf.inst_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc_q <= '0;
      v1   <= 1'b0;
      v2   <= 1'b0;
      v3   <= 1'b0;
      v4   <= 1'b0;
    end else if (adv) begin
      v1 <= conf.run;                          // Bubbles enter until the PE is configured.
      v2 <= v1;
      v3 <= v2;
      v4 <= v3;
      if (conf.run) begin
        pc_q <= (pc_q == conf.pc_max) ? conf.pc_loop : pc_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (adv) begin
      inst1  <= imem[pc_q];
      op2    <= alu_op_t'(inst1[INST_OP_LSB +: $bits(alu_op_t)]);
      a_sel2 <= src_sel_t'(inst1[INST_A_LSB +: $bits(src_sel_t)]);
      b_sel2 <= src_sel_t'(inst1[INST_B_LSB +: $bits(src_sel_t)]);
      dst2   <= dst_sel_t'(inst1[INST_DST_LSB +: $bits(dst_sel_t)]);
      waddr2 <= inst1[INST_RW_LSB +: RF_AW];
      rf2    <= rf[inst1[INST_RR_LSB +: RF_AW]];
      ina2   <= ina;
      inb2   <= inb;
      op3    <= op2;
      dst3   <= dst2;
      waddr3 <= waddr2;
      a3     <= pick(a_sel2, ina2, inb2, rf2, fifo_data);
      b3     <= pick(b_sel2, ina2, inb2, rf2, fifo_data);
      dst4   <= dst3;
      waddr4 <= waddr3;
    end
  end

  pe_alu alu_i (
    .clk    (clk),
    .en     (adv),
    .op     (op3),
    .a      (a3),
    .b      (b3),
    .result (result4)
  );

  always_ff @(posedge clk) begin
    if (adv && v4) begin
      if (dst4 == DST_NA) begin
        outa <= result4;
      end
      if (dst4 == DST_NB) begin
        outb <= result4;
      end
      if (send) begin
        out_data <= result4;
      end
    end
  end

  // Configuration constants win over a pipeline write in the same cycle.
  always_ff @(posedge clk) begin
    if (conf.const_we) begin
      rf[conf.const_addr] <= conf.const_data;
    end else if (adv && v4 && (dst4 == DST_RF)) begin
      rf[waddr4] <= result4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
      warm_cnt  <= '0;
      credits   <= OUT_CRED_W'(OUT_CREDITS);
    end else begin
      out_valid <= adv && send;
      if (adv && to_stream && !warm_done) begin
        warm_cnt <= warm_cnt + 1'b1;
      end
      credits <= credits - OUT_CRED_W'(adv && send) + OUT_CRED_W'(out_credit);
    end
  end

endmodule

// ==== rtl/cgra_io_tile.sv ====
`timescale 1ns/10ps

module cgra_io_tile #(
  parameter cgra_pkg::pe_id_t PE_ID = 8'd0
) (
  input  logic                 clk,
  input  logic                 reset,
  input  cgra_pkg::conf_word_t conf_bus,
  input  logic                 in_valid,
  input  cgra_pkg::data_t      in_data,
  output logic                 in_credit,
  output logic                 out_valid,
  output cgra_pkg::data_t      out_data,
  input  logic                 out_credit,
  output cgra_pkg::data_t      outa,
  output cgra_pkg::data_t      outb,
  input  cgra_pkg::data_t      ina,
  input  cgra_pkg::data_t      inb
);

  import cgra_pkg::*;

  data_t fifo_data;
  logic  fifo_empty;
  logic  fifo_pop;

  conf_if conf_i ();

  conf_reader #(
    .PE_ID (PE_ID)
  ) conf_reader_i (
    .clk      (clk),
    .reset    (reset),
    .conf_bus (conf_bus),
    .conf     (conf_i)
  );

  stream_fifo fifo_i (
    .clk       (clk),
    .reset     (reset),
    .push      (in_valid),
    .push_data (in_data),
    .pop       (fifo_pop),
    .pop_data  (fifo_data),
    .empty     (fifo_empty),
    .credit    (in_credit)
  );

  pe_io pe_i (
    .clk        (clk),
    .reset      (reset),
    .conf       (conf_i),
    .ina        (ina),
    .inb        (inb),
    .outa       (outa),
    .outb       (outb),
    .fifo_data  (fifo_data),
    .fifo_empty (fifo_empty),
    .fifo_pop   (fifo_pop),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

endmodule

// ==== sim/tb_ref_model.svh ====
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

function automatic data_t ref_alu(alu_op_t op, data_t a, data_t b);
  logic [31:0] prod;
  prod = {16'h0000, a} * {16'h0000, b};
  case (op)
    ALU_ADD:  return a + b;
    ALU_SUB:  return a - b;
    ALU_AND:  return a & b;
    ALU_OR:   return a | b;
    ALU_XOR:  return a ^ b;
    ALU_SHL:  return a << 1;
    ALU_SHR:  return a >> 1;
    ALU_PASS: return a;
    ALU_MUL:  return prod[15:0];   // Only the low word of the product is kept.
    default:  return a;
  endcase
endfunction

function automatic data_t ref_operand(src_sel_t sel, data_t na, data_t nb, data_t rfv,
                                      data_t st);
  case (sel)
    SRC_NA:  return na;
    SRC_NB:  return nb;
    SRC_RF:  return rfv;
    default: return st;
  endcase
endfunction

// The op field sits in bits 15:12, a_sel in 11:10 and b_sel in 9:8.
function automatic data_t ref_result(inst_t inst, data_t na, data_t nb, data_t rfv,
                                     data_t st);
  return ref_alu(alu_op_t'(inst[15:12]),
                 ref_operand(src_sel_t'(inst[11:10]), na, nb, rfv, st),
                 ref_operand(src_sel_t'(inst[9:8]), na, nb, rfv, st));
endfunction

`endif

// ==== sim/tb_cgra_io_tile.sv ====
`timescale 1ns/10ps

module tb_cgra_io_tile;

  import cgra_pkg::*;

  `include "tb_ref_model.svh"

  typedef logic [6:0] idx_t;

  localparam pe_id_t MY_ID    = 8'd3;
  localparam pe_id_t OTHER_ID = 8'd5;
  localparam int MAX_CYCLES = 4000;   // 80 words, about 16 stall cycles each, margin of three.

  logic       clk = 1'b0;
  logic       reset;
  conf_word_t conf_bus;
  logic       in_valid;
  data_t      in_data;
  logic       in_credit;
  logic       out_valid;
  data_t      out_data;
  logic       out_credit = 1'b0;
  data_t      outa;
  data_t      outb;
  data_t      ina;
  data_t      inb;

  data_t       in_words [128];
  data_t       exp_mem [128];
  data_t       exp_head;
  data_t       exp_a;
  data_t       exp_b;
  idx_t        rd_idx;
  idx_t        exp_count;
  int          src_credits;
  int          tile_cred;
  int          owed;
  int          errors = 0;
  int          checked = 0;
  int          cycles = 0;
  int          seed = 32'h68407181;
  logic [31:0] rnd;
  logic        give;
  logic        sink_hold;
  logic        phase_end;
  logic        nb_check;

  cgra_io_tile #(
    .PE_ID (MY_ID)
  ) dut_i (
    .clk        (clk),
    .reset      (reset),
    .conf_bus   (conf_bus),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_data   (out_data),
    .out_credit (out_credit),
    .outa       (outa),
    .outb       (outb),
    .ina        (ina),
    .inb        (inb)
  );

  always #5 clk = ~clk;

  assign exp_head = exp_mem[rd_idx];

  // Credit views as seen at the tile ports.
  always @(posedge clk) begin
    if (reset) begin
      src_credits <= FIFO_DEPTH;
      tile_cred   <= OUT_CREDITS;
      rd_idx      <= '0;
    end else begin
      src_credits <= src_credits - int'(in_valid) + int'(in_credit);
      tile_cred   <= tile_cred - int'(out_valid) + int'(out_credit);
      if (out_valid) begin
        rd_idx  <= rd_idx + 7'd1;
        checked <= checked + 1;
      end
    end
  end

  // The sink returns each credit after a random delay unless it is holding them.
  always @(posedge clk) begin
    rnd = $random(seed);
    if (reset) begin
      owed       <= 0;
      out_credit <= 1'b0;
    end else begin
      give = (owed > 0) && !sink_hold && (rnd[1:0] == 2'b00);
      out_credit <= give;
      owed       <= owed + int'(out_valid) - int'(give);
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run stopped after %0d cycles with %0d errors", cycles, errors);
      $display("Test failures found");
      $finish;
    end
  end

  a_out_data: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> (out_data == exp_head)) else begin
    errors = errors + 1;
    $display("Error at %0t: out_data %h, expected %h", $time, out_data, exp_head);
  end

  a_no_extra: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> (rd_idx < exp_count)) else begin
    errors = errors + 1;
    $display("Error at %0t: the tile sent more stream words than expected", $time);
  end

  a_out_credit: assert property (@(posedge clk) disable iff (reset)
      out_valid |-> (tile_cred > 0)) else begin
    errors = errors + 1;
    $display("Error at %0t: the tile sent a word without an output credit", $time);
  end

  a_in_credit: assert property (@(posedge clk) disable iff (reset)
      in_credit |-> (src_credits < FIFO_DEPTH)) else begin
    errors = errors + 1;
    $display("Error at %0t: the tile returned an input credit for a word never sent", $time);
  end

  a_credit_bound: assert property (@(posedge clk) disable iff (reset)
      src_credits <= FIFO_DEPTH) else begin
    errors = errors + 1;
    $display("Error at %0t: more input credits came back than words were sent", $time);
  end

  a_phase_end: assert property (@(posedge clk) disable iff (reset)
      phase_end |-> (rd_idx == exp_count) && (src_credits == FIFO_DEPTH)) else begin
    errors = errors + 1;
    $display("Error at %0t: phase ended with %0d of %0d outputs and %0d input credits",
             $time, rd_idx, exp_count, src_credits);
  end

  a_neighbor: assert property (@(posedge clk) disable iff (reset)
      nb_check |-> (outa == exp_a) && (outb == exp_b)) else begin
    errors = errors + 1;
    $display("Error at %0t: outa %h outb %h, expected %h and %h",
             $time, outa, outb, exp_a, exp_b);
  end

  function automatic inst_t make_inst(alu_op_t op, src_sel_t a, src_sel_t b, dst_sel_t d,
                                      rf_addr_t rr, rf_addr_t rw);
    return {op, a, b, d, rr, rw};
  endfunction

  function automatic conf_word_t conf_word(pe_id_t id, conf_kind_t kind, pc_t addr,
                                           data_t data);
    return {1'b1, id, kind, addr, data, 24'h5a5a5a};   // Spare bits carry junk.
  endfunction

  task automatic do_reset();
    reset <= 1'b1;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
  endtask

  task automatic conf_write(conf_kind_t kind, pc_t addr, data_t data, logic noise);
    @(posedge clk);
    conf_bus <= conf_word(MY_ID, kind, addr, data);
    if (noise) begin
      @(posedge clk);
      conf_bus <= conf_word(OTHER_ID, kind, addr, ~data);
    end
  endtask

  task automatic send_stream(idx_t n);
    idx_t i;
    int   avail;
    i = '0;
    while (i < n) begin
      @(posedge clk);
      avail = src_credits - int'(in_valid) + int'(in_credit);
      if (avail > 0) begin
        in_valid <= 1'b1;
        in_data  <= in_words[i];
        i = i + 7'd1;
      end else begin
        in_valid <= 1'b0;
      end
    end
    @(posedge clk);
    in_valid <= 1'b0;
  endtask

  task automatic end_phase();
    repeat (12) @(posedge clk);
    phase_end <= 1'b1;
    @(posedge clk);
    phase_end <= 1'b0;
  endtask

  task automatic run_stream_test(alu_op_t op, data_t k, idx_t ign, logic noise, idx_t n,
                                 int hold);
    inst_t inst;
    data_t w;
    idx_t  i;
    inst = make_inst(op, SRC_STREAM, SRC_RF, DST_STREAM, 3'd1, 3'd0);
    w = 16'hff10;
    do_reset();
    for (i = '0; i < n + 7'd2; i = i + 7'd1) begin
      in_words[i] = w;
      w = w + 16'h0123;
    end
    for (i = '0; i < n - ign; i = i + 7'd1) begin
      exp_mem[i] = ref_result(inst, 16'h0000, 16'h0000, k, in_words[i + ign]);
    end
    exp_count <= n - ign;
    sink_hold <= (hold > 0);
    conf_write(CONF_INST, 8'd0, inst, noise);
    conf_write(CONF_CONST, 8'd1, k, noise);
    conf_write(CONF_IGNORE, 8'd0, data_t'(ign), noise);
    conf_write(CONF_PC_LOOP, 8'd0, 16'h0000, noise);
    conf_write(CONF_PC_MAX, 8'd0, 16'h0000, noise);   // Written last since it starts the PE.
    @(posedge clk);
    conf_bus <= '0;
    fork
      send_stream(n + 7'd2);   // Two trailing words push the last results out.
      begin
        repeat (hold) @(posedge clk);
        sink_hold <= 1'b0;
      end
    join
    while (rd_idx != exp_count) @(posedge clk);
    end_phase();
  endtask

  task automatic run_neighbor(data_t a, data_t b);
    inst_t i0;
    inst_t i1;
    i0 = make_inst(ALU_ADD, SRC_NA, SRC_NB, DST_NA, 3'd0, 3'd0);
    i1 = make_inst(ALU_SUB, SRC_NA, SRC_NB, DST_NB, 3'd0, 3'd0);
    do_reset();
    ina       <= a;
    inb       <= b;
    exp_a     <= ref_result(i0, a, b, 16'h0000, 16'h0000);
    exp_b     <= ref_result(i1, a, b, 16'h0000, 16'h0000);
    exp_count <= '0;
    conf_write(CONF_INST, 8'd0, i0, 1'b0);
    conf_write(CONF_INST, 8'd1, i1, 1'b0);
    conf_write(CONF_PC_LOOP, 8'd0, 16'h0000, 1'b0);
    conf_write(CONF_PC_MAX, 8'd0, 16'h0001, 1'b0);
    @(posedge clk);
    conf_bus <= '0;
    repeat (12) @(posedge clk);   // Lets the loop fill the pipeline.
    nb_check <= 1'b1;
    repeat (20) @(posedge clk);
    nb_check <= 1'b0;
    end_phase();
  endtask

  initial begin
    reset     <= 1'b1;
    conf_bus  <= '0;
    in_valid  <= 1'b0;
    in_data   <= '0;
    ina       <= '0;
    inb       <= '0;
    sink_hold <= 1'b0;
    phase_end <= 1'b0;
    nb_check  <= 1'b0;
    exp_count <= '0;
    exp_a     <= '0;
    exp_b     <= '0;
    run_stream_test(ALU_ADD, 16'h0123, 7'd0, 1'b0, 7'd16, 0);
    run_stream_test(ALU_ADD, 16'h0123, 7'd0, 1'b1, 7'd16, 0);   // Foreign words in between.
    run_stream_test(ALU_ADD, 16'h0123, 7'd3, 1'b0, 7'd16, 0);
    run_stream_test(ALU_ADD, 16'hff80, 7'd0, 1'b0, 7'd24, 60);  // Sink sits on its credits.
    run_neighbor(16'h1234, 16'h0ff0);
    run_neighbor(16'h0005, 16'h0009);
    repeat (5) @(posedge clk);
    $display("Checks finished with %0d errors over %0d stream outputs", errors, checked);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+sim
rtl/cgra_pkg.sv
rtl/conf_if.sv
rtl/conf_reader.sv
rtl/stream_fifo.sv
rtl/pe_alu.sv
rtl/pe_io.sv
rtl/cgra_io_tile.sv
sim/tb_cgra_io_tile.sv

// ==== Makefile ====
TOP = tb_cgra_io_tile

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
